// File: src/cpl_meter_defines.svh
// completion buffer sizes, request limits and field widths for the completion meter
// include in any file that needs them; the guard makes repeated includes harmless
`ifndef CPL_METER_DEFINES_SVH
`define CPL_METER_DEFINES_SVH

`define CPL_TAG_W            10
`define CPL_BYTE_CNT_W       12

// read completion boundary and buffer data entry size, in bytes
`define CPL_RCB              64
`define CPL_ENTRY_BYTES      16

// kept small so the whole budget is reachable with a handful of reads
`define CPL_MRRS             512
`define CPL_MPS              128

`define CPL_HIP_HDR_ENTRIES  24
`define CPL_HIP_DATA_ENTRIES 96

// worst case cost of one request, the extra entry covers a misaligned start
`define CPL_MAX_HDR_ENTRY    (`CPL_MRRS / `CPL_RCB + 1)
`define CPL_MAX_DATA_ENTRY   (`CPL_MRRS / `CPL_ENTRY_BYTES + 1)

// budgets are oversubscribed by one maximum request so the grant test needs upper bits only
`define CPL_HDR_BUDGET       (`CPL_HIP_HDR_ENTRIES + `CPL_MAX_HDR_ENTRY)
`define CPL_DATA_BUDGET      (`CPL_HIP_DATA_ENTRIES + `CPL_MAX_DATA_ENTRY)

`endif

// File: src/cpl_meter_pkg.sv
// shared vector types and the request kind encoding of the completion meter
// imported by every RTL module of the meter
`default_nettype none

`include "cpl_meter_defines.svh"

package cpl_meter_pkg;

    typedef logic [`CPL_TAG_W-1:0] tag_t;

    // a length of zero stands for 1024 dwords
    typedef logic [9:0] len_dw_t;
    typedef logic [$clog2(`CPL_RCB)-1:0] addr_lo_t;

    // per request cost, sized to hold the largest possible request
    typedef logic [$clog2(`CPL_MAX_HDR_ENTRY)-1:0] hdr_cnt_t;
    typedef logic [$clog2(`CPL_MAX_DATA_ENTRY)-1:0] data_cnt_t;

    typedef logic [$clog2(`CPL_HDR_BUDGET)-1:0] hdr_credit_t;
    typedef logic [$clog2(`CPL_DATA_BUDGET)-1:0] data_credit_t;

    // table word, header remainder in the upper bits and data remainder below
    typedef logic [$bits(hdr_cnt_t)+$bits(data_cnt_t)-1:0] alloc_word_t;

    typedef enum logic [1:0] {
        KIND_WRITE  = 2'd0,
        KIND_READ   = 2'd1,
        KIND_ATOMIC = 2'd2,
        KIND_OTHER  = 2'd3
    } req_kind_e;

endpackage

`default_nettype wire

// File: src/req_stage.sv
// one registered request channel that prices reads and holds them until credit is granted
// non-metered kinds pass straight through with one cycle of latency
`timescale 1ns/1ps
`default_nettype none

`include "cpl_meter_defines.svh"

module req_stage #(
    parameter bit METER_ATOMIC = 1'b0
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   in_valid,
    input  cpl_meter_pkg::req_kind_e    in_kind,
    input  cpl_meter_pkg::tag_t         in_tag,
    input  cpl_meter_pkg::len_dw_t      in_len_dw,
    input  cpl_meter_pkg::addr_lo_t     in_addr_lo,
    output logic                        in_ready,
    output logic                        out_valid,
    output cpl_meter_pkg::req_kind_e    out_kind,
    output cpl_meter_pkg::tag_t         out_tag,
    output cpl_meter_pkg::len_dw_t      out_len_dw,
    output cpl_meter_pkg::addr_lo_t     out_addr_lo,
    input  wire logic                   out_ready,
    output logic                        meter_req,
    output cpl_meter_pkg::tag_t         meter_tag,
    output cpl_meter_pkg::hdr_cnt_t     hdr_cost,
    output cpl_meter_pkg::data_cnt_t    data_cost,
    input  wire logic                   grant
);
    import cpl_meter_pkg::*;

    // dword shifts that turn a length into RCB units and into entry units
    localparam int RCB_SH = $clog2(`CPL_RCB) - 2;
    localparam int ENT_SH = $clog2(`CPL_ENTRY_BYTES) - 2;

    logic      vld_q;
    logic      is_metered;
    logic      misaligned;
    hdr_cnt_t  hdr_cost_in;
    data_cnt_t data_cost_in;

    assign is_metered = (in_kind == KIND_READ) || (METER_ATOMIC && in_kind == KIND_ATOMIC);

    // a start that is not on the completion boundary splits off one extra completion
    assign misaligned   = |in_addr_lo[$bits(addr_lo_t)-1:2];
    assign hdr_cost_in  = hdr_cnt_t'(in_len_dw[9:RCB_SH]) + hdr_cnt_t'(|in_len_dw[RCB_SH-1:0])
                        + hdr_cnt_t'(misaligned);
    assign data_cost_in = data_cnt_t'(in_len_dw[9:ENT_SH]) + data_cnt_t'(|in_len_dw[ENT_SH-1:0])
                        + data_cnt_t'(misaligned);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q     <= 1'b0;
            meter_req <= 1'b0;
        end else begin
            // credit is held from the grant on, even while the output is stalled
            if (grant) begin
                meter_req <= 1'b0;
            end
            if (in_ready) begin
                vld_q     <= in_valid;
                meter_req <= in_valid && is_metered;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            out_kind    <= in_kind;
            out_tag     <= in_tag;
            out_len_dw  <= in_len_dw;
            out_addr_lo <= in_addr_lo;
            hdr_cost    <= hdr_cost_in;
            data_cost   <= data_cost_in;
        end
    end

    assign meter_tag = out_tag;
    assign in_ready  = out_ready && (!meter_req || grant);
    assign out_valid = vld_q && (!meter_req || grant);

endmodule

`default_nettype wire

// File: src/credit_arbiter.sv
// round-robin arbiter between the two request stages and the header and data credit counters
// a winner's cost is charged to the counters and recorded in the allocation table by tag
`timescale 1ns/1ps
`default_nettype none

`include "cpl_meter_defines.svh"

module credit_arbiter (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   meter_req0,
    input  wire logic                   meter_req1,
    input  cpl_meter_pkg::tag_t         meter_tag0,
    input  cpl_meter_pkg::tag_t         meter_tag1,
    input  cpl_meter_pkg::hdr_cnt_t     hdr_cost0,
    input  cpl_meter_pkg::hdr_cnt_t     hdr_cost1,
    input  cpl_meter_pkg::data_cnt_t    data_cost0,
    input  cpl_meter_pkg::data_cnt_t    data_cost1,
    input  cpl_meter_pkg::hdr_cnt_t     hdr_incr,
    input  cpl_meter_pkg::data_cnt_t    data_incr,
    input  wire logic                   wr_b_busy,
    output logic                        grant0,
    output logic                        grant1,
    output logic                        wr_a_en,
    output cpl_meter_pkg::tag_t         wr_a_tag,
    output cpl_meter_pkg::alloc_word_t  wr_a_word
);
    import cpl_meter_pkg::*;

    localparam int HDR_LO  = $bits(hdr_cnt_t);
    localparam int DATA_LO = $bits(data_cnt_t);

    logic         prev_winner;
    logic         arb0;
    logic         arb1;
    logic         credit_ok;
    hdr_credit_t  hdr_cnt;
    data_credit_t data_cnt;
    hdr_cnt_t     hdr_dec;
    data_cnt_t    data_dec;

    // prev_winner set means channel 1 won last, so channel 0 goes first on a tie
    assign arb0 = meter_req0 && (prev_winner || !meter_req1);
    assign arb1 = meter_req1 && (!prev_winner || !meter_req0);

    // the budgets carry one maximum request of headroom, so any count at or above
    // the maximum request size covers whatever the winner costs
    assign credit_ok = (|hdr_cnt[$bits(hdr_credit_t)-1:HDR_LO])
                     && (|data_cnt[$bits(data_credit_t)-1:DATA_LO]);

    // both table write ports land on one RAM port, completions win that cycle
    assign grant0 = arb0 && credit_ok && !wr_b_busy;
    assign grant1 = arb1 && credit_ok && !wr_b_busy;

    assign hdr_dec  = grant1 ? hdr_cost1 : (grant0 ? hdr_cost0 : '0);
    assign data_dec = grant1 ? data_cost1 : (grant0 ? data_cost0 : '0);

    assign wr_a_en   = grant0 || grant1;
    assign wr_a_tag  = grant1 ? meter_tag1 : meter_tag0;
    assign wr_a_word = {hdr_dec, data_dec};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev_winner <= 1'b0;
        end else if (grant1) begin
            prev_winner <= 1'b1;
        end else if (grant0) begin
            prev_winner <= 1'b0;
        end
    end

    // returned credit is added every cycle, whether or not a grant is charged
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdr_cnt  <= hdr_credit_t'(`CPL_HDR_BUDGET);
            data_cnt <= data_credit_t'(`CPL_DATA_BUDGET);
        end else begin
            hdr_cnt  <= hdr_cnt + hdr_credit_t'(hdr_incr) - hdr_credit_t'(hdr_dec);
            data_cnt <= data_cnt + data_credit_t'(data_incr) - data_credit_t'(data_dec);
        end
    end

endmodule

`default_nettype wire

// File: src/alloc_table.sv
// per-tag table of the header and data entries still owed to each outstanding read
// two copies share one registered write; copy B bypasses a read of the tag being written
`timescale 1ns/1ps
`default_nettype none

`include "cpl_meter_defines.svh"

module alloc_table (
    input  wire logic                   clk,
    input  wire logic                   wr_a_en,
    input  cpl_meter_pkg::tag_t         wr_a_tag,
    input  cpl_meter_pkg::alloc_word_t  wr_a_word,
    input  wire logic                   wr_b_en,
    input  cpl_meter_pkg::tag_t         wr_b_tag,
    input  cpl_meter_pkg::alloc_word_t  wr_b_word,
    input  wire logic                   rd_a_en,
    input  cpl_meter_pkg::tag_t         rd_a_tag,
    output cpl_meter_pkg::alloc_word_t  rd_a_word,
    input  wire logic                   rd_b_en,
    input  cpl_meter_pkg::tag_t         rd_b_tag,
    output cpl_meter_pkg::alloc_word_t  rd_b_word
);
    import cpl_meter_pkg::*;

    localparam int DEPTH = 1 << `CPL_TAG_W;

    alloc_word_t mem_a [DEPTH];
    alloc_word_t mem_b [DEPTH];

    logic        wr_en_q;
    tag_t        wr_tag_q;
    alloc_word_t wr_word_q;
    alloc_word_t ram_b_q;
    alloc_word_t bypass_word;
    logic        bypass_b;

    // completion updates take priority, the arbiter holds grants off when both collide
    always_ff @(posedge clk) begin
        wr_en_q <= wr_a_en || wr_b_en;
        if (wr_b_en) begin
            wr_tag_q  <= wr_b_tag;
            wr_word_q <= wr_b_word;
        end else begin
            wr_tag_q  <= wr_a_tag;
            wr_word_q <= wr_a_word;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_q) begin
            mem_a[wr_tag_q] <= wr_word_q;
            mem_b[wr_tag_q] <= wr_word_q;
        end
        if (rd_a_en) begin
            rd_a_word <= mem_a[rd_a_tag];
        end
        if (rd_b_en) begin
            ram_b_q <= mem_b[rd_b_tag];
        end
    end

    // back-to-back completions on one tag need the word being written this cycle
    always_ff @(posedge clk) begin
        bypass_b    <= wr_en_q && rd_b_en && (wr_tag_q == rd_b_tag);
        bypass_word <= wr_word_q;
    end

    assign rd_b_word = bypass_b ? bypass_word : ram_b_q;

endmodule

`default_nettype wire

// File: src/cpl_return.sv
// completion and timeout decode that gives buffer credit back to the arbiter
// partial completions update the tag's remainder, a final one or a timeout frees all of it
`timescale 1ns/1ps
`default_nettype none

`include "cpl_meter_defines.svh"

module cpl_return (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       cpl_valid,
    input  cpl_meter_pkg::tag_t             cpl_tag,
    input  cpl_meter_pkg::len_dw_t          cpl_len_dw,
    input  wire logic [`CPL_BYTE_CNT_W-1:0] cpl_byte_cnt,
    input  wire logic [1:0]                 cpl_lower_addr,
    input  wire logic [2:0]                 cpl_status,
    input  wire logic                       cplto_valid,
    input  cpl_meter_pkg::tag_t             cplto_tag,
    output logic                            rd_a_en,
    output cpl_meter_pkg::tag_t             rd_a_tag,
    output logic                            rd_b_en,
    output cpl_meter_pkg::tag_t             rd_b_tag,
    input  cpl_meter_pkg::alloc_word_t      rd_a_word,
    input  cpl_meter_pkg::alloc_word_t      rd_b_word,
    output logic                            wr_b_en,
    output cpl_meter_pkg::tag_t             wr_b_tag,
    output cpl_meter_pkg::alloc_word_t      wr_b_word,
    output logic                            wr_b_busy,
    output cpl_meter_pkg::hdr_cnt_t         hdr_incr,
    output cpl_meter_pkg::data_cnt_t        data_incr
);
    import cpl_meter_pkg::*;

    localparam int LEN_W  = $clog2(`CPL_MPS) - 1;
    localparam int ENT_SH = $clog2(`CPL_ENTRY_BYTES);
    localparam int DW     = $bits(data_cnt_t);
    localparam int HW     = $bits(hdr_cnt_t);

    logic [$clog2(`CPL_MPS):0]  act_bytes;
    logic [`CPL_BYTE_CNT_W:0]   byte_cnt_full;
    logic [10:0]                len_full;
    logic                       is_last;
    data_cnt_t                  ret_entries;
    logic                       last1, v2, last2, to2;
    data_cnt_t                  ret1, ret2;
    tag_t                       tag2;
    logic                       prev_valid;
    tag_t                       prev_tag;
    alloc_word_t                prev_word;
    alloc_word_t                src_word;
    hdr_cnt_t                   cpl_hdr_inc, to_hdr_inc;
    data_cnt_t                  cpl_data_inc, to_data_inc;

    // zero encodes the largest value in both the length and the byte count
    assign len_full      = {cpl_len_dw == '0, cpl_len_dw};
    assign byte_cnt_full = {cpl_byte_cnt == '0, cpl_byte_cnt};
    assign is_last       = (byte_cnt_full <= {len_full, 2'b00}) || (cpl_status != 3'b000);

    // bytes carried, a partial first dword still takes a whole data entry
    assign act_bytes   = {cpl_len_dw[LEN_W-1:0], 2'b00} - cpl_lower_addr;
    assign ret_entries = DW'(act_bytes[$clog2(`CPL_MPS):ENT_SH]) + DW'(|act_bytes[ENT_SH-1:0]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_a_en <= 1'b0;
            rd_b_en <= 1'b0;
            v2      <= 1'b0;
            to2     <= 1'b0;
        end else begin
            rd_a_en <= cplto_valid;
            rd_b_en <= cpl_valid;
            v2      <= rd_b_en;
            to2     <= rd_a_en;
        end
    end

    always_ff @(posedge clk) begin
        rd_a_tag <= cplto_tag;
        rd_b_tag <= cpl_tag;
        last1    <= is_last;
        ret1     <= ret_entries;
        tag2     <= rd_b_tag;
        last2    <= last1;
        ret2     <= ret1;
    end

    // the table lags one write behind a back-to-back completion on the same tag
    assign src_word  = (prev_valid && prev_tag == tag2) ? prev_word : rd_b_word;
    assign wr_b_en   = v2 && !last2;
    assign wr_b_busy = wr_b_en;
    assign wr_b_tag  = tag2;
    assign wr_b_word = {src_word[DW +: HW] - HW'(1), src_word[DW-1:0] - ret2};

    always_ff @(posedge clk) begin
        prev_tag  <= tag2;
        prev_word <= wr_b_word;
        if (!rst_n) begin
            prev_valid <= 1'b0;
        end else begin
            prev_valid <= wr_b_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpl_hdr_inc  <= '0;
            cpl_data_inc <= '0;
            to_hdr_inc   <= '0;
            to_data_inc  <= '0;
            hdr_incr     <= '0;
            data_incr    <= '0;
        end else begin
            cpl_hdr_inc  <= !v2 ? '0 : (last2 ? src_word[DW +: HW] : HW'(1));
            cpl_data_inc <= !v2 ? '0 : (last2 ? src_word[DW-1:0] : ret2);
            to_hdr_inc   <= to2 ? rd_a_word[DW +: HW] : '0;
            to_data_inc  <= to2 ? rd_a_word[DW-1:0] : '0;
            hdr_incr     <= cpl_hdr_inc + to_hdr_inc;
            data_incr    <= cpl_data_inc + to_data_inc;
        end
    end

endmodule

`default_nettype wire

// File: src/cpl_meter_top.sv
// completion meter top level, holds metered reads on both channels until buffer credit is free
// channel 0 meters reads only, channel 1 meters reads and atomics
`timescale 1ns/1ps
`default_nettype none

`include "cpl_meter_defines.svh"

module cpl_meter_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       rq0_valid,
    output logic                            rq0_ready,
    input  cpl_meter_pkg::req_kind_e        rq0_kind,
    input  cpl_meter_pkg::tag_t             rq0_tag,
    input  cpl_meter_pkg::len_dw_t          rq0_len_dw,
    input  cpl_meter_pkg::addr_lo_t         rq0_addr_lo,
    output logic                            out0_valid,
    input  wire logic                       out0_ready,
    output cpl_meter_pkg::req_kind_e        out0_kind,
    output cpl_meter_pkg::tag_t             out0_tag,
    output cpl_meter_pkg::len_dw_t          out0_len_dw,
    output cpl_meter_pkg::addr_lo_t         out0_addr_lo,
    input  wire logic                       rq1_valid,
    output logic                            rq1_ready,
    input  cpl_meter_pkg::req_kind_e        rq1_kind,
    input  cpl_meter_pkg::tag_t             rq1_tag,
    input  cpl_meter_pkg::len_dw_t          rq1_len_dw,
    input  cpl_meter_pkg::addr_lo_t         rq1_addr_lo,
    output logic                            out1_valid,
    input  wire logic                       out1_ready,
    output cpl_meter_pkg::req_kind_e        out1_kind,
    output cpl_meter_pkg::tag_t             out1_tag,
    output cpl_meter_pkg::len_dw_t          out1_len_dw,
    output cpl_meter_pkg::addr_lo_t         out1_addr_lo,
    input  wire logic                       cpl_valid,
    input  cpl_meter_pkg::tag_t             cpl_tag,
    input  cpl_meter_pkg::len_dw_t          cpl_len_dw,
    input  wire logic [`CPL_BYTE_CNT_W-1:0] cpl_byte_cnt,
    input  wire logic [1:0]                 cpl_lower_addr,
    input  wire logic [2:0]                 cpl_status,
    input  wire logic                       cplto_valid,
    input  cpl_meter_pkg::tag_t             cplto_tag
);
    import cpl_meter_pkg::*;

    logic        meter_req0, meter_req1, grant0, grant1;
    tag_t        meter_tag0, meter_tag1;
    hdr_cnt_t    hdr_cost0, hdr_cost1, hdr_incr;
    data_cnt_t   data_cost0, data_cost1, data_incr;
    logic        wr_a_en, wr_b_en, wr_b_busy, rd_a_en, rd_b_en;
    tag_t        wr_a_tag, wr_b_tag, rd_a_tag, rd_b_tag;
    alloc_word_t wr_a_word, wr_b_word, rd_a_word, rd_b_word;

    req_stage #(.METER_ATOMIC(1'b0)) u_req_stage0 (
        .clk, .rst_n,
        .in_valid(rq0_valid), .in_kind(rq0_kind), .in_tag(rq0_tag),
        .in_len_dw(rq0_len_dw), .in_addr_lo(rq0_addr_lo), .in_ready(rq0_ready),
        .out_valid(out0_valid), .out_kind(out0_kind), .out_tag(out0_tag),
        .out_len_dw(out0_len_dw), .out_addr_lo(out0_addr_lo), .out_ready(out0_ready),
        .meter_req(meter_req0), .meter_tag(meter_tag0),
        .hdr_cost(hdr_cost0), .data_cost(data_cost0), .grant(grant0)
    );

    req_stage #(.METER_ATOMIC(1'b1)) u_req_stage1 (
        .clk, .rst_n,
        .in_valid(rq1_valid), .in_kind(rq1_kind), .in_tag(rq1_tag),
        .in_len_dw(rq1_len_dw), .in_addr_lo(rq1_addr_lo), .in_ready(rq1_ready),
        .out_valid(out1_valid), .out_kind(out1_kind), .out_tag(out1_tag),
        .out_len_dw(out1_len_dw), .out_addr_lo(out1_addr_lo), .out_ready(out1_ready),
        .meter_req(meter_req1), .meter_tag(meter_tag1),
        .hdr_cost(hdr_cost1), .data_cost(data_cost1), .grant(grant1)
    );

    credit_arbiter u_credit_arbiter (
        .clk, .rst_n,
        .meter_req0, .meter_req1, .meter_tag0, .meter_tag1,
        .hdr_cost0, .hdr_cost1, .data_cost0, .data_cost1,
        .hdr_incr, .data_incr, .wr_b_busy,
        .grant0, .grant1,
        .wr_a_en, .wr_a_tag, .wr_a_word
    );

    alloc_table u_alloc_table (
        .clk,
        .wr_a_en, .wr_a_tag, .wr_a_word,
        .wr_b_en, .wr_b_tag, .wr_b_word,
        .rd_a_en, .rd_a_tag, .rd_a_word,
        .rd_b_en, .rd_b_tag, .rd_b_word
    );

    cpl_return u_cpl_return (
        .clk, .rst_n,
        .cpl_valid, .cpl_tag, .cpl_len_dw, .cpl_byte_cnt, .cpl_lower_addr, .cpl_status,
        .cplto_valid, .cplto_tag,
        .rd_a_en, .rd_a_tag, .rd_b_en, .rd_b_tag, .rd_a_word, .rd_b_word,
        .wr_b_en, .wr_b_tag, .wr_b_word, .wr_b_busy,
        .hdr_incr, .data_incr
    );

endmodule

`default_nettype wire

// File: sim/tb_cpl_meter.sv
// self-checking testbench for the completion meter driven by random requests from an LFSR
// a model tracks the outstanding tags and both credit totals to predict where reads stop
`timescale 1ns/1ps
`default_nettype none

`include "cpl_meter_defines.svh"

module tb_cpl_meter;
    import cpl_meter_pkg::*;

    localparam int TEST_LEN = 400;
    localparam int N_TESTS  = 6;
    // a grant needs a counter bit set above the width of the largest request cost
    localparam int HDR_GATE  = 16;
    localparam int DATA_GATE = 64;

    logic clk, rst_n;
    logic rq0_valid, rq0_ready, out0_valid, out0_ready;
    logic rq1_valid, rq1_ready, out1_valid, out1_ready;
    req_kind_e rq0_kind, rq1_kind, out0_kind, out1_kind;
    tag_t rq0_tag, rq1_tag, out0_tag, out1_tag;
    len_dw_t rq0_len_dw, rq1_len_dw, out0_len_dw, out1_len_dw;
    addr_lo_t rq0_addr_lo, rq1_addr_lo, out0_addr_lo, out1_addr_lo;
    logic cpl_valid, cplto_valid;
    tag_t cpl_tag, cplto_tag;
    len_dw_t cpl_len_dw;
    logic [`CPL_BYTE_CNT_W-1:0] cpl_byte_cnt;
    logic [1:0] cpl_lower_addr;
    logic [2:0] cpl_status;

    logic [31:0] lfsr = 32'hd443cf45;
    logic [31:0] req0_q[$], req1_q[$], exp0_q[$], exp1_q[$], cpl_q[$], to_q[$];
    int outstanding[$];
    int order_q[$];
    int hdr_rem[1024], data_rem[1024], req_len[1024], req_addr[1024];
    int hdr_avail = `CPL_HDR_BUDGET;
    int data_avail = `CPL_DATA_BUDGET;
    int next_tag = 0;
    int errors = 0, n_checks = 0, n_tests = 0, failed_tests = 0, test_err0 = 0;
    bit all_ready = 0;
    bit record = 0;
    string cur_test;

    cpl_meter_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (N_TESTS * TEST_LEN * 20) @(posedge clk);
        $display("run stopped by the watchdog during test %s", cur_test);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic bit metered(int ch, logic [1:0] kind);
        return kind == KIND_READ || (ch == 1 && kind == KIND_ATOMIC);
    endfunction

    function automatic bit model_ok();
        return hdr_avail >= HDR_GATE && data_avail >= DATA_GATE;
    endfunction

    task automatic check(string what, logic [31:0] exp, logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            $display("FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic send(int ch, int kind, int len, int addr);
        logic [31:0] w;
        w = {4'b0, 6'(addr), 10'(len), 10'(next_tag), 2'(kind)};
        next_tag = (next_tag + 1) % 1024;
        if (ch == 0) req0_q.push_back(w);
        else req1_q.push_back(w);
    endtask

    // charge a metered request when it leaves the stage with its cost rounded up to RCB and entry units
    task automatic charge(logic [31:0] w);
        int tag, len, addr, mis;
        tag = w[11:2];
        len = w[21:12];
        addr = w[27:22];
        mis = (addr != 0);
        hdr_rem[tag] = (len * 4 + `CPL_RCB - 1) / `CPL_RCB + mis;
        data_rem[tag] = (len * 4 + `CPL_ENTRY_BYTES - 1) / `CPL_ENTRY_BYTES + mis;
        hdr_avail -= hdr_rem[tag];
        data_avail -= data_rem[tag];
        req_len[tag] = len;
        req_addr[tag] = addr;
        outstanding.push_back(tag);
    endtask

    task automatic take_out(int ch, logic [31:0] w);
        logic [31:0] e;
        if ((ch == 0 && exp0_q.size() == 0) || (ch == 1 && exp1_q.size() == 0)) begin
            $display("%s: channel %0d forwarded a request that was never sent", cur_test, ch);
            errors++;
            return;
        end
        if (ch == 0) e = exp0_q.pop_front();
        else e = exp1_q.pop_front();
        check($sformatf("channel %0d fields", ch), e, w);
        if (record) order_q.push_back(ch);
        if (metered(ch, w[1:0])) charge(w);
    endtask

    // sample transfers on the rising edge, then drive the next inputs on the falling edge
    task automatic tick();
        logic [31:0] w;
        @(posedge clk);
        if (rq0_valid && rq0_ready) exp0_q.push_back(req0_q.pop_front());
        if (rq1_valid && rq1_ready) exp1_q.push_back(req1_q.pop_front());
        if (out0_valid && out0_ready)
            take_out(0, {4'b0, out0_addr_lo, out0_len_dw, out0_tag, out0_kind});
        if (out1_valid && out1_ready)
            take_out(1, {4'b0, out1_addr_lo, out1_len_dw, out1_tag, out1_kind});
        @(negedge clk);
        rq0_valid = req0_q.size() > 0;
        if (rq0_valid) begin
            {rq0_addr_lo, rq0_len_dw, rq0_tag} = req0_q[0][27:2];
            rq0_kind = req_kind_e'(req0_q[0][1:0]);
        end
        rq1_valid = req1_q.size() > 0;
        if (rq1_valid) begin
            {rq1_addr_lo, rq1_len_dw, rq1_tag} = req1_q[0][27:2];
            rq1_kind = req_kind_e'(req1_q[0][1:0]);
        end
        out0_ready = all_ready || (rand_bits(2) != 0);
        out1_ready = all_ready || (rand_bits(2) != 0);
        cpl_valid = cpl_q.size() > 0;
        if (cpl_valid) begin
            w = cpl_q.pop_front();
            {cpl_byte_cnt, cpl_len_dw, cpl_tag} = w;
        end
        cplto_valid = to_q.size() > 0;
        if (cplto_valid) begin
            w = to_q.pop_front();
            cplto_tag = w[9:0];
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((req0_q.size() + req1_q.size() + exp0_q.size() + exp1_q.size()
                + cpl_q.size() + to_q.size()) > 0 && n < TEST_LEN) begin
            tick();
            n++;
        end
        if (n >= TEST_LEN) begin
            $display("%s: requests or completions were still pending after %0d cycles",
                     cur_test, n);
            errors++;
        end
        // let returned credit reach the counters
        repeat (8) tick();
    endtask

    task automatic expect_stall(int ch);
        repeat (40) tick();
        check("held request", 1, (ch == 0) ? exp0_q.size() : exp1_q.size());
    endtask

    task automatic exhaust(int ch);
        while (model_ok()) begin
            send(ch, KIND_READ, rand_bits(7) + 1, rand_bits(4) << 2);
            drain();
        end
    endtask

    task automatic release_one();
        int tag;
        tag = outstanding.pop_front();
        to_q.push_back(32'(tag));
        hdr_avail += hdr_rem[tag];
        data_avail += data_rem[tag];
    endtask

    task automatic release_all();
        while (outstanding.size() > 0) release_one();
        drain();
    endtask

    // completions split on RCB boundaries and the one that carries the remaining bytes is last
    task automatic complete_tag(int tag);
        int rem, off, c, e;
        rem = req_len[tag] * 4;
        off = req_addr[tag];
        while (rem > 0) begin
            c = `CPL_RCB - (off % `CPL_RCB);
            if (c > rem) c = rem;
            cpl_q.push_back({12'(rem), 10'(c / 4), 10'(tag)});
            if (rem <= c) begin
                hdr_avail += hdr_rem[tag];
                data_avail += data_rem[tag];
            end else begin
                e = (c + `CPL_ENTRY_BYTES - 1) / `CPL_ENTRY_BYTES;
                hdr_rem[tag] -= 1;
                data_rem[tag] -= e;
                hdr_avail += 1;
                data_avail += e;
            end
            rem -= c;
            off += c;
        end
    endtask

    task automatic complete_all();
        while (outstanding.size() > 0) complete_tag(outstanding.pop_front());
        drain();
    endtask

    // once every tag is answered the DUT counters are back at the full budgets
    task automatic check_budgets();
        check("header credit total", `CPL_HDR_BUDGET, i_dut.u_credit_arbiter.hdr_cnt);
        check("data credit total", `CPL_DATA_BUDGET, i_dut.u_credit_arbiter.data_cnt);
    endtask

    task automatic start_test(string name);
        cur_test = name;
        test_err0 = errors;
        n_tests++;
    endtask

    task automatic end_test();
        if (errors != test_err0) failed_tests++;
        $display("test %s done with %0d errors", cur_test, errors - test_err0);
    endtask

    initial begin
        rst_n = 1'b0;
        {rq0_valid, rq1_valid, cpl_valid, cplto_valid} = '0;
        {out0_ready, out1_ready} = 2'b11;
        rq0_kind = KIND_WRITE;
        rq1_kind = KIND_WRITE;
        {rq0_tag, rq1_tag, rq0_len_dw, rq1_len_dw, rq0_addr_lo, rq1_addr_lo} = '0;
        {cpl_tag, cpl_len_dw, cpl_byte_cnt, cpl_lower_addr, cpl_status, cplto_tag} = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("passthrough");
        repeat (2) begin
            repeat (8) send(rand_bits(1), rand_bits(2), rand_bits(2) + 1, rand_bits(4) << 2);
            drain();
            release_all();
        end
        check_budgets();
        end_test();

        start_test("unmetered_kinds");
        exhaust(0);
        send(0, KIND_WRITE, 8, 0);
        send(0, KIND_ATOMIC, 2, 0);
        send(0, KIND_OTHER, 1, 4);
        send(1, KIND_WRITE, 16, 0);
        send(1, KIND_OTHER, 1, 0);
        drain();
        send(1, KIND_ATOMIC, 2, 0);
        expect_stall(1);
        release_all();
        release_all();
        check_budgets();
        end_test();

        start_test("credit_stop");
        exhaust(0);
        send(0, KIND_READ, rand_bits(7) + 1, rand_bits(4) << 2);
        expect_stall(0);
        end_test();

        start_test("split_completions");
        complete_all();
        complete_all();
        check_budgets();
        end_test();

        start_test("timeout_release");
        exhaust(1);
        send(1, KIND_READ, rand_bits(7) + 1, rand_bits(4) << 2);
        expect_stall(1);
        while (!model_ok() && outstanding.size() > 0) release_one();
        drain();
        release_all();
        check_budgets();
        end_test();

        start_test("round_robin");
        all_ready = 1;
        record = 1;
        repeat (8) begin
            send(0, KIND_READ, 4, 0);
            send(1, KIND_READ, 4, 0);
        end
        drain();
        record = 0;
        all_ready = 0;
        check("grant count", 16, order_q.size());
        for (int i = 1; i < order_q.size(); i++) begin
            check("alternating channel", 32'(!order_q[i - 1]), 32'(order_q[i]));
        end
        release_all();
        check_budgets();
        end_test();

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 n_tests, failed_tests, n_checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/cpl_meter_pkg.sv
src/req_stage.sv
src/credit_arbiter.sv
src/alloc_table.sv
src/cpl_return.sv
src/cpl_meter_top.sv
sim/tb_cpl_meter.sv

// File: Bender.yml
package:
  name: cpl_meter

sources:
  - include_dirs:
      - src
    files:
      - src/cpl_meter_pkg.sv
      - src/req_stage.sv
      - src/credit_arbiter.sv
      - src/alloc_table.sv
      - src/cpl_return.sv
      - src/cpl_meter_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/tb_cpl_meter.sv
